// ==== instrStateManager.f ====
+incdir+source
source/cmdFormatPkg.sv
source/seqStatePkg.sv
source/saveArbiter.sv
source/fetchPlanner.sv
source/stepSequencer.sv
source/instrStateManager.sv
tb/instrStateManager_props.sv
tb/instrStateManager_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module instrStateManager_tb \
  -f instrStateManager.f \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VinstrStateManager_tb 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "TEST PASS" <<< "$simOut"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb/instrStateManager_tb.sv ====
`timescale 1ns/1ps

`include "instrStateManager_cfg.svh"

module instrStateManager_tb;
  import seqStatePkg::*;

  localparam int clkPeriod = 8;
  localparam int numRows = 8;
  // longest trace plus slack
  localparam int stepsPerRow = 24;

  logic [`SM_CMD_WIDTH-1:0] command;
  logic [`SM_DATA_WIDTH-1:0] cond;
  logic isCondRead;
  logic isSrc1Read;
  logic isSrc0Read;
  logic chanWaitNextTime;
  logic next_state;
  logic rst;
  stepStateT state;
  logic nextStateDone;
  logic ipSaveAllowed;
  logic dstSaveAllowed;
  logic dstSavePtrAllowed;
  logic condSaveAllowed;
  logic src1SaveAllowed;
  logic src0SaveAllowed;

  // stimulus table, one row per instruction
  logic [`SM_CMD_WIDTH-1:0] cmdTab [numRows];
  bit condZeroTab [numRows];
  // read flags as {cond, src1, src0}
  logic [2:0] readTab [numRows];
  bit chanWaitTab [numRows];
  // save flags as {ip, dst, dstPtr, cond, src1, src0}
  logic [5:0] expFlagTab [numRows];
  // expected trace from WAIT_FOR_START to FINISH_END
  stepStateT traceTab [numRows][$];

  int errCount;
  logic expDone;

  instrStateManager i_instrStateManager (
    .command           (command),
    .cond              (cond),
    .isCondRead        (isCondRead),
    .isSrc1Read        (isSrc1Read),
    .isSrc0Read        (isSrc0Read),
    .chanWaitNextTime  (chanWaitNextTime),
    .next_state        (next_state),
    .rst               (rst),
    .state             (state),
    .nextStateDone     (nextStateDone),
    .ipSaveAllowed     (ipSaveAllowed),
    .dstSaveAllowed    (dstSaveAllowed),
    .dstSavePtrAllowed (dstSavePtrAllowed),
    .condSaveAllowed   (condSaveAllowed),
    .src1SaveAllowed   (src1SaveAllowed),
    .src0SaveAllowed   (src0SaveAllowed)
  );

  // step clock
  initial begin
    next_state = 1'b0;
    forever #(clkPeriod / 2) next_state = ~next_state;
  end

  // watchdog, twice the worst case run
  initial begin
    #(numRows * stepsPerRow * clkPeriod * 2);
    $display("watchdog expired before all table rows finished");
    $display("TEST FAIL");
    $fatal(1, "simulation timed out");
  end

  task automatic checkEq(input int actual, input int expected, input string what);
    if (actual != expected) begin
      errCount++;
      $display("CHECK FAILED at time %0t: %s, got %0d, expected %0d",
               $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // all six permission outputs against the row
  task automatic verifySaveFlags(input int r);
    logic [5:0] want;
    want = expFlagTab[r];
    checkEq(ipSaveAllowed, want[5], $sformatf("row %0d ipSaveAllowed", r));
    checkEq(dstSaveAllowed, want[4], $sformatf("row %0d dstSaveAllowed", r));
    checkEq(dstSavePtrAllowed, want[3], $sformatf("row %0d dstSavePtrAllowed", r));
    checkEq(condSaveAllowed, want[2], $sformatf("row %0d condSaveAllowed", r));
    checkEq(src1SaveAllowed, want[1], $sformatf("row %0d src1SaveAllowed", r));
    checkEq(src0SaveAllowed, want[0], $sformatf("row %0d src0SaveAllowed", r));
  endtask

  // command word from its fields, ptrs as {cnd, d, s0, s1}
  function automatic logic [`SM_CMD_WIDTH-1:0] packCmd(
    input logic [3:0] op,
    input logic [1:0] cndF,
    input logic [1:0] dF,
    input logic [1:0] s0F,
    input logic [1:0] s1F,
    input logic [3:0] ptrs,
    input logic [3:0] cnd,
    input logic [3:0] d,
    input logic [3:0] s0,
    input logic [3:0] s1
  );
    logic [`SM_CMD_WIDTH-1:0] w;
    w = '0;
    w[`SM_FLD_OPCODE +: 4] = op;
    w[`SM_FLD_CND_FLAGS +: 2] = cndF;
    w[`SM_FLD_D_FLAGS +: 2] = dF;
    w[`SM_FLD_S0_FLAGS +: 2] = s0F;
    w[`SM_FLD_S1_FLAGS +: 2] = s1F;
    w[`SM_FLD_CND_PTR] = ptrs[3];
    w[`SM_FLD_D_PTR] = ptrs[2];
    w[`SM_FLD_S0_PTR] = ptrs[1];
    w[`SM_FLD_S1_PTR] = ptrs[0];
    w[`SM_FLD_CND_NUM +: 4] = cnd;
    w[`SM_FLD_D_NUM +: 4] = d;
    w[`SM_FLD_S0_NUM +: 4] = s0;
    w[`SM_FLD_S1_NUM +: 4] = s1;
    return w;
  endfunction

  task automatic setRow(input int r, input logic [`SM_CMD_WIDTH-1:0] cmd,
                        input bit condIsZero, input logic [2:0] reads,
                        input bit chanWait, input logic [5:0] expFlags);
    cmdTab[r] = cmd;
    condZeroTab[r] = condIsZero;
    readTab[r] = reads;
    chanWaitTab[r] = chanWait;
    expFlagTab[r] = expFlags;
  endtask

  task automatic loadTable();
    // plain command, every operand read, four write-backs
    setRow(0, packCmd(4'h0, 2'b01, 2'b01, 2'b10, 2'b01, 4'b0000, 1, 2, 3, 4),
           0, 3'b000, 0, 6'b110111);
    traceTab[0] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, WRITE_REG_IP, READ_COND, READ_SRC1,
      READ_SRC0, ALU_BEGIN, ALU_RESULTS, WRITE_PREP, WRITE_DST, WRITE_COND, WRITE_SRC1,
      WRITE_SRC0, FINISH_BEGIN, FINISH_END};
    // cond on ip, src0 forwarded from src1, src1 and dst through pointers
    setRow(1, packCmd(4'h0, 2'b00, 2'b11, 2'b00, 2'b00, 4'b0101, 15, 6, 5, 5),
           0, 3'b010, 0, 6'b101000);
    traceTab[1] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, WRITE_REG_IP, FILL_COND, READ_SRC1,
      READ_SRC1_P, FILL_SRC0, READ_DST, ALU_BEGIN, ALU_RESULTS, WRITE_PREP, WRITE_DST_P,
      FINISH_BEGIN, FINISH_END};
    // cond pointer, src1 and dst forwarded from cond
    setRow(2, packCmd(4'h0, 2'b00, 2'b10, 2'b11, 2'b00, 4'b1100, 7, 7, 0, 7),
           0, 3'b100, 0, 6'b110000);
    traceTab[2] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, WRITE_REG_IP, READ_COND, READ_COND_P,
      FILL_SRC1, FILL_DST_P, ALU_BEGIN, ALU_RESULTS, WRITE_PREP, WRITE_DST_P, WRITE_DST,
      FINISH_BEGIN, FINISH_END};
    // condition false, ip already written so no second pass
    setRow(3, packCmd(4'h0, 2'b00, 2'b01, 2'b11, 2'b11, 4'b0000, 1, 2, 0, 0),
           1, 3'b000, 0, 6'b100000);
    traceTab[3] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, WRITE_REG_IP, READ_COND, ALU_BEGIN,
      ALU_RESULTS, WRITE_PREP, FINISH_BEGIN, FINISH_END};
    // dst is ip, auto advance blocked
    setRow(4, packCmd(4'h0, 2'b11, 2'b01, 2'b11, 2'b00, 4'b0000, 0, 15, 0, 3),
           0, 3'b000, 0, 6'b010000);
    traceTab[4] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, READ_SRC1, ALU_BEGIN, ALU_RESULTS,
      WRITE_PREP, WRITE_DST, FINISH_BEGIN, FINISH_END};
    // channel command, ip write after the ALU
    setRow(5, packCmd(`SM_CMD_CHN, 2'b00, 2'b01, 2'b11, 2'b00, 4'b0000, 1, 3, 0, 2),
           0, 3'b000, 0, 6'b110000);
    traceTab[5] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, READ_COND, READ_SRC1, ALU_BEGIN,
      ALU_RESULTS, WRITE_REG_IP, WRITE_PREP, WRITE_DST, FINISH_BEGIN, FINISH_END};
    // channel wait, straight to finish
    setRow(6, packCmd(`SM_CMD_CHN, 2'b00, 2'b01, 2'b11, 2'b00, 4'b0000, 1, 3, 0, 2),
           0, 3'b000, 1, 6'b110000);
    traceTab[6] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, READ_COND, READ_SRC1, ALU_BEGIN,
      FINISH_BEGIN, FINISH_END};
    // dst and src1 on r4, dst wins, WRITE_SRC1 skipped
    setRow(7, packCmd(4'h0, 2'b11, 2'b01, 2'b10, 2'b01, 4'b0000, 0, 4, 5, 4),
           0, 3'b000, 0, 6'b110001);
    traceTab[7] = '{WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, PREEXECUTE, WRITE_REG_IP, READ_SRC1, READ_SRC0,
      ALU_BEGIN, ALU_RESULTS, WRITE_PREP, WRITE_DST, WRITE_SRC0, FINISH_BEGIN,
      FINISH_END};
  endtask

  // one step, sampled half a cycle after the edge
  task automatic stepClock();
    @(posedge next_state);
    @(negedge next_state);
    expDone = ~expDone;
    checkEq(nextStateDone, expDone, "nextStateDone toggle");
  endtask

  initial begin
    int row;
    int idx;
    logic [`SM_DATA_WIDTH-1:0] pick;
    command = '0;
    cond = '0;
    isCondRead = 1'b0;
    isSrc1Read = 1'b0;
    isSrc0Read = 1'b0;
    chanWaitNextTime = 1'b0;
    rst = 1'b1;
    errCount = 0;
    expDone = 1'b0;
    void'($urandom(32577));
    loadTable();

    repeat (3) @(posedge next_state);
    @(negedge next_state);
    rst = 1'b0;
    checkEq(state, WAIT_FOR_START, "state after reset");
    checkEq(nextStateDone, 0, "nextStateDone after reset");

    for (row = 0; row < numRows; row++) begin
      // held for the whole instruction, set while idle
      command = cmdTab[row];
      if (condZeroTab[row]) begin
        cond = '0;
      end else begin
        do pick = $urandom; while (pick == '0);
        cond = pick;
      end
      {isCondRead, isSrc1Read, isSrc0Read} = readTab[row];
      chanWaitNextTime = chanWaitTab[row];
      checkEq(state, traceTab[row][0], $sformatf("row %0d idle state", row));
      for (idx = 1; idx < traceTab[row].size(); idx++) begin
        stepClock();
        checkEq(state, traceTab[row][idx], $sformatf("row %0d step %0d state", row, idx));
        verifySaveFlags(row);
      end
      // FINISH_END wraps to idle
      stepClock();
      checkEq(state, WAIT_FOR_START, $sformatf("row %0d return to idle", row));
    end

    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/instrStateManager_props.sv ====
`timescale 1ns/1ps

module instrStateManager_props (
  input logic                   next_state,
  input logic                   rst,
  input seqStatePkg::stepStateT state,
  input logic                   nextStateDone,
  input logic                   dstSaveAllowed,
  input logic                   dstSavePtrAllowed
);
  import seqStatePkg::*;

  // one toggle per step once the previous edge was out of reset
  doneToggles: assert property (
    @(posedge next_state) disable iff (rst)
      $past(rst) == 1'b0 |-> nextStateDone != $past(nextStateDone)
  ) else $error("nextStateDone held its value across a step");

  // plain and pointer destination saves exclude each other
  dstSaveExclusive: assert property (
    @(posedge next_state) !(dstSaveAllowed && dstSavePtrAllowed)
  ) else $error("both destination save flags high");

  // held idle through reset, first edge skipped
  idleInReset: assert property (
    @(posedge next_state) rst && $past(rst) |-> state == WAIT_FOR_START
  ) else $error("state left WAIT_FOR_START during reset");

endmodule

bind stepSequencer instrStateManager_props i_props (
  .next_state        (next_state),
  .rst               (rst),
  .state             (state),
  .nextStateDone     (nextStateDone),
  .dstSaveAllowed    (dstSaveAllowed),
  .dstSavePtrAllowed (dstSavePtrAllowed)
);

// ==== source/instrStateManager.sv ====
`timescale 1ns/1ps

`include "instrStateManager_cfg.svh"

module instrStateManager (
  input  logic [`SM_CMD_WIDTH-1:0]   command,
  input  logic [`SM_DATA_WIDTH-1:0]  cond,
  input  logic                       isCondRead,
  input  logic                       isSrc1Read,
  input  logic                       isSrc0Read,
  input  logic                       chanWaitNextTime,
  input  logic                       next_state,
  input  logic                       rst,
  output seqStatePkg::stepStateT     state,
  output logic                       nextStateDone,
  output logic                       ipSaveAllowed,
  output logic                       dstSaveAllowed,
  output logic                       dstSavePtrAllowed,
  output logic                       condSaveAllowed,
  output logic                       src1SaveAllowed,
  output logic                       src0SaveAllowed
);
  import cmdFormatPkg::*;
  import seqStatePkg::*;

  regNumT regNumD, regNumCnd, regNumS1, regNumS0;
  regFlagsT dstFlags, condFlags, src1Flags, src0Flags;
  logic dstPtr, condPtr, src1Ptr, src0Ptr;
  opcodeT opcode;
  logic condZero;

  // candidate next fetch stages
  stepStateT afterIpStage, afterCond, afterSrc1, afterSrc0;

  // command word split
  assign regNumS1  = command[`SM_FLD_S1_NUM +: `SM_REG_NUM_WIDTH];
  assign regNumS0  = command[`SM_FLD_S0_NUM +: `SM_REG_NUM_WIDTH];
  assign regNumD   = command[`SM_FLD_D_NUM +: `SM_REG_NUM_WIDTH];
  assign regNumCnd = command[`SM_FLD_CND_NUM +: `SM_REG_NUM_WIDTH];
  assign src1Ptr   = command[`SM_FLD_S1_PTR];
  assign src0Ptr   = command[`SM_FLD_S0_PTR];
  assign dstPtr    = command[`SM_FLD_D_PTR];
  assign condPtr   = command[`SM_FLD_CND_PTR];
  assign src1Flags = command[`SM_FLD_S1_FLAGS +: `SM_FLAGS_WIDTH];
  assign src0Flags = command[`SM_FLD_S0_FLAGS +: `SM_FLAGS_WIDTH];
  assign dstFlags  = command[`SM_FLD_D_FLAGS +: `SM_FLAGS_WIDTH];
  assign condFlags = command[`SM_FLD_CND_FLAGS +: `SM_FLAGS_WIDTH];
  assign opcode    = command[`SM_FLD_OPCODE +: `SM_OPCODE_WIDTH];

  assign condZero = (cond == '0);

  saveArbiter i_saveArbiter (
    .regNumD           (regNumD),
    .regNumCnd         (regNumCnd),
    .regNumS1          (regNumS1),
    .regNumS0          (regNumS0),
    .dstFlags          (dstFlags),
    .condFlags         (condFlags),
    .src1Flags         (src1Flags),
    .src0Flags         (src0Flags),
    .dstPtr            (dstPtr),
    .cond              (cond),
    .ipSaveAllowed     (ipSaveAllowed),
    .dstSaveAllowed    (dstSaveAllowed),
    .dstSavePtrAllowed (dstSavePtrAllowed),
    .condSaveAllowed   (condSaveAllowed),
    .src1SaveAllowed   (src1SaveAllowed),
    .src0SaveAllowed   (src0SaveAllowed)
  );

  fetchPlanner i_fetchPlanner (
    .regNumD      (regNumD),
    .regNumCnd    (regNumCnd),
    .regNumS1     (regNumS1),
    .regNumS0     (regNumS0),
    .condFlags    (condFlags),
    .src1Flags    (src1Flags),
    .src0Flags    (src0Flags),
    .dstPtr       (dstPtr),
    .isCondRead   (isCondRead),
    .isSrc1Read   (isSrc1Read),
    .isSrc0Read   (isSrc0Read),
    .afterIpStage (afterIpStage),
    .afterCond    (afterCond),
    .afterSrc1    (afterSrc1),
    .afterSrc0    (afterSrc0)
  );

  stepSequencer i_stepSequencer (
    .next_state        (next_state),
    .rst               (rst),
    .opcode            (opcode),
    .condFlags         (condFlags),
    .dstFlags          (dstFlags),
    .condPtr           (condPtr),
    .src1Ptr           (src1Ptr),
    .src0Ptr           (src0Ptr),
    .dstPtr            (dstPtr),
    .condZero          (condZero),
    .chanWaitNextTime  (chanWaitNextTime),
    .afterIpStage      (afterIpStage),
    .afterCond         (afterCond),
    .afterSrc1         (afterSrc1),
    .afterSrc0         (afterSrc0),
    .ipSaveAllowed     (ipSaveAllowed),
    .dstSaveAllowed    (dstSaveAllowed),
    .dstSavePtrAllowed (dstSavePtrAllowed),
    .condSaveAllowed   (condSaveAllowed),
    .src1SaveAllowed   (src1SaveAllowed),
    .src0SaveAllowed   (src0SaveAllowed),
    .state             (state),
    .nextStateDone     (nextStateDone)
  );

endmodule

// ==== source/stepSequencer.sv ====
`timescale 1ns/1ps

`include "instrStateManager_cfg.svh"

module stepSequencer (
  input  logic                    next_state,
  input  logic                    rst,
  input  cmdFormatPkg::opcodeT    opcode,
  input  cmdFormatPkg::regFlagsT  condFlags,
  input  cmdFormatPkg::regFlagsT  dstFlags,
  input  logic                    condPtr,
  input  logic                    src1Ptr,
  input  logic                    src0Ptr,
  input  logic                    dstPtr,
  input  logic                    condZero,
  input  logic                    chanWaitNextTime,
  input  seqStatePkg::stepStateT  afterIpStage,
  input  seqStatePkg::stepStateT  afterCond,
  input  seqStatePkg::stepStateT  afterSrc1,
  input  seqStatePkg::stepStateT  afterSrc0,
  input  logic                    ipSaveAllowed,
  input  logic                    dstSaveAllowed,
  input  logic                    dstSavePtrAllowed,
  input  logic                    condSaveAllowed,
  input  logic                    src1SaveAllowed,
  input  logic                    src0SaveAllowed,
  output seqStatePkg::stepStateT  state,
  output logic                    nextStateDone
);
  import cmdFormatPkg::*;
  import seqStatePkg::*;

  stepStateT nextState;

  // per instruction bookkeeping
  logic condRead;
  logic ipWritten;
  logic cmdIsChan;

  // false condition loops back once to advance ip
  logic condRestart;

  // write-back tail after each write stage
  stepStateT afterDstWrite;
  stepStateT afterCondWrite;
  stepStateT afterSrc1Write;

  assign condRestart = ipSaveAllowed && condZero && ~ipWritten && ~cmdIsChan;

  assign afterSrc1Write = src0SaveAllowed ? WRITE_SRC0 : FINISH_BEGIN;
  assign afterCondWrite = src1SaveAllowed ? WRITE_SRC1 : afterSrc1Write;
  assign afterDstWrite  = condSaveAllowed ? WRITE_COND : afterCondWrite;

  always_comb begin
    nextState = WAIT_FOR_START;
    case (state)
      // linear start, fetch and finish chains
      WAIT_FOR_START, START_BEGIN, READ_MEM_SIZE_1, AFTER_MEM_SIZE_READ,
      START_READ_CMD, START_READ_CMD_P, FINISH_BEGIN: begin
        nextState = stepStateT'(state + 1'b1);
      end
      FINISH_END: begin
        nextState = WAIT_FOR_START;
      end
      // ip write first unless blocked or deferred by a channel command
      PREEXECUTE: begin
        if (~ipSaveAllowed || cmdIsChan) begin
          nextState = afterIpStage;
        end else begin
          nextState = WRITE_REG_IP;
        end
      end
      WRITE_REG_IP: begin
        if (cmdIsChan) begin
          nextState = WRITE_PREP;
        end else if (opUsed(condFlags) && ~condRead) begin
          nextState = afterIpStage;
        end else begin
          // cond already fetched on the first pass
          nextState = afterCond;
        end
      end
      READ_COND, FILL_COND: begin
        if (condPtr) begin
          nextState = READ_COND_P;
        end else if (condRestart) begin
          nextState = WRITE_REG_IP;
        end else begin
          nextState = afterCond;
        end
      end
      READ_COND_P: begin
        if (condRestart) begin
          nextState = WRITE_REG_IP;
        end else begin
          nextState = afterCond;
        end
      end
      READ_SRC1, FILL_SRC1: begin
        nextState = src1Ptr ? READ_SRC1_P : afterSrc1;
      end
      READ_SRC1_P: begin
        nextState = afterSrc1;
      end
      READ_SRC0, FILL_SRC0: begin
        nextState = src0Ptr ? READ_SRC0_P : afterSrc0;
      end
      READ_SRC0_P: begin
        nextState = afterSrc0;
      end
      READ_DST, FILL_DST_P: begin
        nextState = ALU_BEGIN;
      end
      // channel wait cuts the instruction short
      ALU_BEGIN: begin
        nextState = chanWaitNextTime ? FINISH_BEGIN : ALU_RESULTS;
      end
      // channel commands update ip after the ALU
      ALU_RESULTS: begin
        nextState = cmdIsChan ? WRITE_REG_IP : WRITE_PREP;
      end
      WRITE_PREP: begin
        if (dstSaveAllowed) begin
          nextState = dstPtr ? WRITE_DST_P : WRITE_DST;
        end else if (dstSavePtrAllowed) begin
          nextState = WRITE_DST_P;
        end else begin
          nextState = afterDstWrite;
        end
      end
      WRITE_DST_P: begin
        // pointer target first, then the register itself when marked
        nextState = opWritesBack(dstFlags) ? WRITE_DST : afterDstWrite;
      end
      WRITE_DST: begin
        nextState = afterDstWrite;
      end
      WRITE_COND: begin
        nextState = afterCondWrite;
      end
      WRITE_SRC1: begin
        nextState = afterSrc1Write;
      end
      WRITE_SRC0: begin
        nextState = FINISH_BEGIN;
      end
      default: begin
        nextState = WAIT_FOR_START;
      end
    endcase
  end

  always_ff @(posedge next_state or posedge rst) begin
    if (rst) begin
      state         <= WAIT_FOR_START;
      nextStateDone <= 1'b0;
      condRead      <= 1'b0;
      ipWritten     <= 1'b0;
      cmdIsChan     <= 1'b0;
    end else begin
      state <= nextState;
      // one toggle per step tells the caller the step is taken
      nextStateDone <= ~nextStateDone;
      case (state)
        // fresh instruction
        WAIT_FOR_START: begin
          condRead  <= 1'b0;
          ipWritten <= 1'b0;
        end
        // opcode valid once the command word is in
        START_READ_CMD_P: begin
          cmdIsChan <= (opcode == `SM_CMD_CHN);
        end
        WRITE_REG_IP: begin
          ipWritten <= 1'b1;
        end
        READ_COND, FILL_COND, READ_COND_P: begin
          condRead <= 1'b1;
        end
        default: begin
          condRead <= condRead;
        end
      endcase
    end
  end

endmodule

// ==== source/fetchPlanner.sv ====
`timescale 1ns/1ps

module fetchPlanner (
  input  cmdFormatPkg::regNumT    regNumD,
  input  cmdFormatPkg::regNumT    regNumCnd,
  input  cmdFormatPkg::regNumT    regNumS1,
  input  cmdFormatPkg::regNumT    regNumS0,
  input  cmdFormatPkg::regFlagsT  condFlags,
  input  cmdFormatPkg::regFlagsT  src1Flags,
  input  cmdFormatPkg::regFlagsT  src0Flags,
  input  logic                    dstPtr,
  input  logic                    isCondRead,
  input  logic                    isSrc1Read,
  input  logic                    isSrc0Read,
  output seqStatePkg::stepStateT  afterIpStage,
  output seqStatePkg::stepStateT  afterCond,
  output seqStatePkg::stepStateT  afterSrc1,
  output seqStatePkg::stepStateT  afterSrc0
);
  import cmdFormatPkg::*;
  import seqStatePkg::*;

  logic condUsed;
  logic src1Used;
  logic src0Used;

  // operand value already on hand, no bus read needed
  logic condFill;
  logic src1Fill;
  logic src0Fill;
  logic dstFill;

  stepStateT condStage;
  stepStateT src1Stage;
  stepStateT src0Stage;
  stepStateT dstStage;

  assign condUsed = opUsed(condFlags);
  assign src1Used = opUsed(src1Flags);
  assign src0Used = opUsed(src0Flags);

  // ip comes from the pointer register, never from memory
  assign condFill = isIpReg(regNumCnd);

  // forward from an earlier operand of the same register
  assign src1Fill = isIpReg(regNumS1)
    || (condUsed && regNumS1 == regNumCnd && isCondRead);

  assign src0Fill = isIpReg(regNumS0)
    || (condUsed && regNumS0 == regNumCnd && isCondRead)
    || (src1Used && regNumS0 == regNumS1 && isSrc1Read);

  assign dstFill = isIpReg(regNumD)
    || (condUsed && regNumD == regNumCnd && isCondRead)
    || (src1Used && regNumD == regNumS1 && isSrc1Read)
    || (src0Used && regNumD == regNumS0 && isSrc0Read);

  // fetch stage per operand
  assign condStage = condFill ? FILL_COND : READ_COND;
  assign src1Stage = src1Fill ? FILL_SRC1 : READ_SRC1;
  assign src0Stage = src0Fill ? FILL_SRC0 : READ_SRC0;
  assign dstStage  = dstFill  ? FILL_DST_P : READ_DST;

  // chained from the back, each point skips empty slots
  // destination only fetched when addressed through a pointer
  assign afterSrc0    = dstPtr   ? dstStage  : ALU_BEGIN;
  assign afterSrc1    = src0Used ? src0Stage : afterSrc0;
  assign afterCond    = src1Used ? src1Stage : afterSrc1;
  assign afterIpStage = condUsed ? condStage : afterCond;

endmodule

// ==== source/saveArbiter.sv ====
`timescale 1ns/1ps

`include "instrStateManager_cfg.svh"

module saveArbiter (
  input  cmdFormatPkg::regNumT       regNumD,
  input  cmdFormatPkg::regNumT       regNumCnd,
  input  cmdFormatPkg::regNumT       regNumS1,
  input  cmdFormatPkg::regNumT       regNumS0,
  input  cmdFormatPkg::regFlagsT     dstFlags,
  input  cmdFormatPkg::regFlagsT     condFlags,
  input  cmdFormatPkg::regFlagsT     src1Flags,
  input  cmdFormatPkg::regFlagsT     src0Flags,
  input  logic                       dstPtr,
  input  logic [`SM_DATA_WIDTH-1:0]  cond,
  output logic                       ipSaveAllowed,
  output logic                       dstSaveAllowed,
  output logic                       dstSavePtrAllowed,
  output logic                       condSaveAllowed,
  output logic                       src1SaveAllowed,
  output logic                       src0SaveAllowed
);
  import cmdFormatPkg::*;

  logic condPass;
  logic condWb;
  logic src1Wb;
  logic src0Wb;

  // no condition operand means always execute
  assign condPass = ~opUsed(condFlags) || (cond != '0);

  assign condWb = opWritesBack(condFlags);
  assign src1Wb = opWritesBack(src1Flags);
  assign src0Wb = opWritesBack(src0Flags);

  // plain destination register
  assign dstSaveAllowed = opUsed(dstFlags) && condPass;
  // destination only through its pointer
  assign dstSavePtrAllowed = ~opUsed(dstFlags) && dstPtr && condPass;

  // later operands win on a shared register
  // destination beats everything, then src0, then src1, cond last
  assign condSaveAllowed = condWb
    && (regNumD != regNumCnd || ~dstSaveAllowed)
    && (regNumS1 != regNumCnd || ~src1Wb)
    && (regNumS0 != regNumCnd || ~src0Wb);

  assign src1SaveAllowed = src1Wb
    && (regNumD != regNumS1 || ~dstSaveAllowed)
    && (regNumS0 != regNumS1 || ~src0Wb);

  assign src0SaveAllowed = src0Wb
    && (regNumD != regNumS0 || ~dstSaveAllowed);

  // ip auto-advance blocked when the instruction itself writes ip
  assign ipSaveAllowed = ~(
       (isIpReg(regNumD) && dstSaveAllowed)
    || (condWb && isIpReg(regNumCnd))
    || (src1Wb && isIpReg(regNumS1))
    || (src0Wb && isIpReg(regNumS0))
  );

endmodule

// ==== source/seqStatePkg.sv ====
`include "instrStateManager_cfg.svh"

package seqStatePkg;

  // step states in sequence order
  // start chain and finish chain rely on consecutive codes
  typedef enum logic [`SM_STATE_WIDTH-1:0] {
    // start and command fetch
    WAIT_FOR_START      = 5'd0,
    START_BEGIN         = 5'd1,
    READ_MEM_SIZE_1     = 5'd2,
    AFTER_MEM_SIZE_READ = 5'd3,
    START_READ_CMD      = 5'd4,
    START_READ_CMD_P    = 5'd5,
    PREEXECUTE          = 5'd6,
    WRITE_REG_IP        = 5'd7,
    // operand fetch
    READ_COND           = 5'd8,
    FILL_COND           = 5'd9,
    READ_COND_P         = 5'd10,
    READ_SRC1           = 5'd11,
    FILL_SRC1           = 5'd12,
    READ_SRC1_P         = 5'd13,
    READ_SRC0           = 5'd14,
    FILL_SRC0           = 5'd15,
    READ_SRC0_P         = 5'd16,
    READ_DST            = 5'd17,
    FILL_DST_P          = 5'd18,
    // execute
    ALU_BEGIN           = 5'd19,
    ALU_RESULTS         = 5'd20,
    // write back
    WRITE_PREP          = 5'd21,
    WRITE_DST           = 5'd22,
    WRITE_DST_P         = 5'd23,
    WRITE_COND          = 5'd24,
    WRITE_SRC1          = 5'd25,
    WRITE_SRC0          = 5'd26,
    // finish
    FINISH_BEGIN        = 5'd27,
    FINISH_END          = 5'd28
  } stepStateT;

endpackage

// ==== source/cmdFormatPkg.sv ====
`include "instrStateManager_cfg.svh"

package cmdFormatPkg;

  // register number of an operand
  typedef logic [`SM_REG_NUM_WIDTH-1:0] regNumT;

  // operand flag pair
  // 11 means the operand slot is empty
  // odd parity means the operand gets written back
  typedef logic [`SM_FLAGS_WIDTH-1:0] regFlagsT;

  // command opcode nibble
  typedef logic [`SM_OPCODE_WIDTH-1:0] opcodeT;

  // operand takes part in the instruction
  function automatic logic opUsed(
    input regFlagsT flags
  );
    return ~&flags;
  endfunction

  // operand is a result and goes back to its register
  function automatic logic opWritesBack(
    input regFlagsT flags
  );
    return ^flags;
  endfunction

  // register number names the instruction pointer
  function automatic logic isIpReg(
    input regNumT num
  );
    return num == `SM_REG_IP;
  endfunction

endpackage

// ==== source/instrStateManager_cfg.svh ====
`ifndef INSTR_STATE_MANAGER_CFG_SVH
`define INSTR_STATE_MANAGER_CFG_SVH

// word widths
`define SM_CMD_WIDTH 32
`define SM_DATA_WIDTH 32

// operand field widths
`define SM_REG_NUM_WIDTH 4
`define SM_FLAGS_WIDTH 2
`define SM_OPCODE_WIDTH 4

// step state register width
`define SM_STATE_WIDTH 5

// register numbers, low bit of each
`define SM_FLD_S1_NUM 0
`define SM_FLD_S0_NUM 4
`define SM_FLD_D_NUM 8
`define SM_FLD_CND_NUM 12

// single pointer bits
`define SM_FLD_S1_PTR 16
`define SM_FLD_S0_PTR 17
`define SM_FLD_D_PTR 18
`define SM_FLD_CND_PTR 19

// flag pairs, low bit of each
`define SM_FLD_S1_FLAGS 20
`define SM_FLD_S0_FLAGS 22
`define SM_FLD_D_FLAGS 24
`define SM_FLD_CND_FLAGS 26

// opcode nibble on top
`define SM_FLD_OPCODE 28

// instruction pointer lives in the last register
`define SM_REG_IP 4'd15
// channel command opcode
`define SM_CMD_CHN 4'hC

`endif
